// ==== sim/matvec8_vectors.txt ====
# Per case: new_matrix flag, 64 matrix words row-major if flag is 1, 8 vector words,
# then 8 expected 28-bit row sums in row order (all decimal)
1
0 -1 -2 -3 -4 -5 -6 -7
1 0 -1 -2 -3 -4 -5 -6
2 1 0 -1 -2 -3 -4 -5
3 2 1 0 -1 -2 -3 -4
4 3 2 1 0 -1 -2 -3
5 4 3 2 1 0 -1 -2
6 5 4 3 2 1 0 -1
7 6 5 4 3 2 1 0
1 2 3 4 5 6 7 8
-168 -132 -96 -60 -24 12 48 84
0
2 0 0 0 0 0 0 1
-7 -4 -1 2 5 8 11 14
1
-8192 -8192 -8192 -8192 -8192 -8192 -8192 -8192
8191 8191 8191 8191 8191 8191 8191 8191
-8192 -8192 -8192 -8192 -8192 -8192 -8192 -8192
8191 8191 8191 8191 8191 8191 8191 8191
-8192 -8192 -8192 -8192 -8192 -8192 -8192 -8192
8191 8191 8191 8191 8191 8191 8191 8191
-8192 -8192 -8192 -8192 -8192 -8192 -8192 -8192
8191 8191 8191 8191 8191 8191 8191 8191
-8192 -8192 -8192 -8192 -8192 -8192 -8192 -8192
0 65536 0 65536 0 65536 0 65536

// ==== matvec8.f ====
+incdir+src
src/matvec_data_pkg.sv
src/matvec_ctrl_pkg.sv
src/operand_sequencer.sv
src/dot_product_pipe.sv
src/result_fifo.sv
src/matvec8.sv
sim/matvec8_assertions.sv
sim/matvec8_tb.sv

// ==== Bender.yml ====
package:
  name: matvec8

sources:
  - include_dirs:
      - src
    files:
      - src/matvec_data_pkg.sv
      - src/matvec_ctrl_pkg.sv
      - src/operand_sequencer.sv
      - src/dot_product_pipe.sv
      - src/result_fifo.sv
      - src/matvec8.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/matvec8_assertions.sv
      - sim/matvec8_tb.sv

// ==== sim/matvec8_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matvec_params.svh"

module matvec8_tb
    import matvec_data_pkg::*;
;

    logic     clk;
    logic     reset;
    logic     input_valid;
    logic     input_ready;
    operand_t input_data;
    logic     new_matrix;
    logic     output_valid;
    logic     output_ready;
    result_t  output_data;

    logic     case_flag [$];
    operand_t word_q [$];
    result_t  exp_q [$];
    int       value_errors = 0;
    int       other_errors = 0;
    int       num_cases = 0;
    bit       loaded = 0;
    bit       random_ready = 0;

    matvec8 i_matvec8 (
        .clk          (clk),
        .reset        (reset),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .input_data   (input_data),
        .new_matrix   (new_matrix),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .output_data  (output_data)
    );

    always #5 clk = ~clk;

    task automatic read_vectors();
        int     fd;
        int     flag;
        int     value;
        string  line;
        fd = $fopen("sim/matvec8_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/matvec8_vectors.txt");
            other_errors++;
            return;
        end
        void'($fgets(line, fd));  // Two header lines describe the columns
        void'($fgets(line, fd));
        while ($fscanf(fd, "%d", flag) == 1) begin
            case_flag.push_back(flag != 0);
            for (int i = 0; i < ((flag != 0) ? 72 : 8); i++) begin
                void'($fscanf(fd, "%d", value));
                word_q.push_back(operand_t'(value));
            end
            for (int i = 0; i < `MATVEC_N; i++) begin
                void'($fscanf(fd, "%d", value));
                exp_q.push_back(result_t'(value));
            end
            num_cases++;
        end
        $fclose(fd);
    endtask

    // Holds the word until the DUT takes it on a rising edge
    task automatic send_word(input operand_t value, input logic flag);
        input_valid = 1'b1;
        input_data  = value;
        new_matrix  = flag;
        @(posedge clk);
        while (!input_ready) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic check_ready_low(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            if (input_ready !== 1'b0) begin
                $display("[FAIL] %0t input_ready expected 0 got %b", $time, input_ready);
                value_errors++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Output back-pressure, random only while random_ready is set
    initial begin
        void'($urandom(99));
        forever begin
            @(posedge clk);
            #1;
            output_ready <= random_ready ? 1'($urandom % 2) : 1'b1;
        end
    end

    // Output monitor, checks each transfer against the next expected row
    always @(posedge clk) begin
        if (!reset && output_valid && output_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output transfer at %0t with no result expected", $time);
                other_errors++;
            end else begin
                if (output_data !== exp_q[0]) begin
                    $display("[FAIL] %0t output_data expected %0d got %0d",
                             $time, exp_q[0], output_data);
                    value_errors++;
                end
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (num_cases * 200 + 100) @(posedge clk);
        $display("Timeout after %0d cycles with %0d results outstanding",
                 num_cases * 200 + 100, exp_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        int idx;
        clk          = 1'b0;
        reset        = 1'b1;
        input_valid  = 1'b0;
        input_data   = '0;
        new_matrix   = 1'b0;
        output_ready = 1'b1;
        read_vectors();
        loaded = 1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        if (input_ready !== 1'b1 || output_valid !== 1'b0) begin
            $display("[FAIL] %0t input_ready/output_valid expected 1/0 got %b/%b",
                     $time, input_ready, output_valid);
            value_errors++;
        end
        idx = 0;
        for (int k = 0; k < num_cases; k++) begin
            random_ready = (k >= 1);  // Later cases see output back-pressure
            for (int i = 0; i < (case_flag[k] ? 72 : 8); i++) begin
                send_word(word_q[idx], case_flag[k]);
                idx++;
            end
            input_valid = 1'b0;
            check_ready_low(`MATVEC_N + 1);  // WAIT_SPACE plus eight COMPUTE cycles
        end
        wait (exp_q.size() == 0);
        random_ready = 0;
        repeat (10) @(posedge clk);
        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/matvec8_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matvec_params.svh"

module matvec8_assertions (
    input wire logic                                  clk,
    input wire logic                                  reset,
    input wire logic                                  push,
    input wire logic                                  pop_valid,
    input wire logic                                  pop_ready,
    input wire logic [`MATVEC_RESULT_W-1:0]           pop_data,
    input wire logic [$clog2(`MATVEC_FIFO_DEPTH)-1:0] wr_ptr,
    input wire logic [$clog2(`MATVEC_FIFO_DEPTH)-1:0] rd_ptr,
    input wire logic [3:0]                            count
);

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(push && count == `MATVEC_FIFO_DEPTH))
        else $error("Push into a full result FIFO");

    // Pointers that meet mean empty unless the count says full
    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        (pop_valid && pop_ready) |-> (rd_ptr != wr_ptr) || (count == `MATVEC_FIFO_DEPTH))
        else $error("Pop from an empty result FIFO");

    // Head entry must hold while the consumer stalls
    data_stable_on_stall: assert property (@(posedge clk) disable iff (reset)
        (pop_valid && !pop_ready) |=> $stable(pop_data))
        else $error("pop_data changed during a stall");

endmodule

bind result_fifo matvec8_assertions i_matvec8_assertions (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .wr_ptr    (wr_ptr),
    .rd_ptr    (rd_ptr),
    .count     (count)
);

`default_nettype wire

// ==== src/matvec8.sv ====
`timescale 1ns/1ps
`default_nettype none

module matvec8
    import matvec_data_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     input_valid,
    output logic     input_ready,
    input  operand_t input_data,
    input  logic     new_matrix,
    output logic     output_valid,
    input  logic     output_ready,
    output result_t  output_data
);

    logic         row_valid;
    operand_row_t w_row;
    operand_row_t x_row;
    logic         sum_valid;
    result_t      sum;
    logic         fifo_empty;

    operand_sequencer i_operand_sequencer (
        .clk         (clk),
        .reset       (reset),
        .input_valid (input_valid),
        .input_ready (input_ready),
        .input_data  (input_data),
        .new_matrix  (new_matrix),
        .fifo_empty  (fifo_empty),
        .row_valid   (row_valid),
        .w_row       (w_row),
        .x_row       (x_row)
    );

    dot_product_pipe i_dot_product_pipe (
        .clk       (clk),
        .reset     (reset),
        .row_valid (row_valid),
        .w_row     (w_row),
        .x_row     (x_row),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    result_fifo #(
        .item_t (result_t)
    ) i_result_fifo (
        .clk       (clk),
        .reset     (reset),
        .push      (sum_valid),
        .push_data (sum),
        .pop_valid (output_valid),
        .pop_ready (output_ready),
        .pop_data  (output_data),
        .empty     (fifo_empty)
    );

endmodule

`default_nettype wire

// ==== src/result_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matvec_params.svh"

module result_fifo #(
    parameter type item_t = logic signed [`MATVEC_RESULT_W-1:0]
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_data,
    output logic  pop_valid,
    input  logic  pop_ready,
    output item_t pop_data,
    output logic  empty
);

    localparam int DEPTH = `MATVEC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign pop = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    assign pop_valid = (count != '0);
    assign empty     = (count == '0);
    assign pop_data  = mem[rd_ptr];  // Head entry, steady until popped

endmodule

`default_nettype wire

// ==== src/dot_product_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matvec_params.svh"

module dot_product_pipe
    import matvec_data_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         row_valid,
    input  operand_row_t w_row,
    input  operand_row_t x_row,
    output logic         sum_valid,
    output result_t      sum
);

    localparam int N = `MATVEC_N;
    localparam int STAGES = `MATVEC_MULT_STAGES;

    operand_t w_q [N];
    operand_t x_q [N];
    logic     in_valid_q;

    product_t          prod_q [STAGES][N];
    logic [STAGES-1:0] mult_valid_q;

    result_t lvl1_q [N/2];
    result_t lvl2_q [N/4];
    logic    lvl1_valid_q;
    logic    lvl2_valid_q;

    // Valid bits run alongside the data and are the only reset state
    always_ff @(posedge clk) begin
        if (reset) begin
            in_valid_q   <= 1'b0;
            mult_valid_q <= '0;
            lvl1_valid_q <= 1'b0;
            lvl2_valid_q <= 1'b0;
            sum_valid    <= 1'b0;
        end else begin
            in_valid_q      <= row_valid;
            mult_valid_q[0] <= in_valid_q;
            for (int k = 1; k < STAGES; k++) begin
                mult_valid_q[k] <= mult_valid_q[k-1];
            end
            lvl1_valid_q <= mult_valid_q[STAGES-1];
            lvl2_valid_q <= lvl1_valid_q;
            sum_valid    <= lvl2_valid_q;
        end
    end

    always_ff @(posedge clk) begin
        w_q <= w_row;
        x_q <= x_row;

        // Extra stages after the multiply let synthesis retime the multiplier
        for (int i = 0; i < N; i++) begin
            prod_q[0][i] <= w_q[i] * x_q[i];
        end
        for (int k = 1; k < STAGES; k++) begin
            prod_q[k] <= prod_q[k-1];
        end

        for (int i = 0; i < N/2; i++) begin
            lvl1_q[i] <= prod_q[STAGES-1][2*i] + prod_q[STAGES-1][2*i+1];
        end
        for (int i = 0; i < N/4; i++) begin
            lvl2_q[i] <= lvl1_q[2*i] + lvl1_q[2*i+1];
        end
        sum <= lvl2_q[0] + lvl2_q[1];  // Overflow wraps at the result width
    end

endmodule

`default_nettype wire

// ==== src/operand_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "matvec_params.svh"

module operand_sequencer
    import matvec_data_pkg::*;
    import matvec_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         input_valid,
    output logic         input_ready,
    input  operand_t     input_data,
    input  logic         new_matrix,
    input  logic         fifo_empty,
    output logic         row_valid,
    output operand_row_t w_row,
    output operand_row_t x_row
);

    localparam row_idx_t LAST = row_idx_t'(`MATVEC_N - 1);

    seq_state_t state;
    row_idx_t   col;
    row_idx_t   row;

    // Bank c holds column c, addressed by row
    operand_t w_mem [`MATVEC_N][`MATVEC_N];
    operand_t x_q [`MATVEC_N];

    logic accept;
    logic first_word;
    logic wr_w;
    logic wr_x;

    assign input_ready = (state == LOAD_MATRIX) || (state == LOAD_VECTOR);
    assign accept      = input_valid && input_ready;
    assign first_word  = (col == '0) && (row == '0);  // Counters are zero whenever a load begins

    // A load that starts with new_matrix low skips straight to the vector
    assign wr_w = accept && (state == LOAD_MATRIX) && (new_matrix || !first_word);
    assign wr_x = accept && ((state == LOAD_VECTOR) ||
                             ((state == LOAD_MATRIX) && first_word && !new_matrix));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= LOAD_MATRIX;
            col   <= '0;
            row   <= '0;
        end else begin
            case (state)
                LOAD_MATRIX: begin
                    if (accept) begin
                        col <= col + 1'b1;
                        if (wr_x) begin
                            state <= LOAD_VECTOR;  // Vector word 0 already taken
                        end else if (col == LAST) begin
                            row <= row + 1'b1;
                            if (row == LAST) begin
                                state <= LOAD_VECTOR;
                            end
                        end
                    end
                end
                LOAD_VECTOR: begin
                    if (accept) begin
                        col <= col + 1'b1;
                        if (col == LAST) begin
                            state <= WAIT_SPACE;
                        end
                    end
                end
                WAIT_SPACE: begin
                    if (fifo_empty) begin
                        state <= COMPUTE;
                    end
                end
                COMPUTE: begin
                    row <= row + 1'b1;
                    if (row == LAST) begin
                        state <= LOAD_MATRIX;
                    end
                end
                default: begin
                    state <= LOAD_MATRIX;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_w) begin
            w_mem[col][row] <= input_data;
        end
        if (wr_x) begin
            x_q[col] <= input_data;
        end
    end

    assign row_valid = (state == COMPUTE);

    // All banks are read at the same address, giving one full matrix row
    always_comb begin
        for (int c = 0; c < `MATVEC_N; c++) begin
            w_row[c] = w_mem[c][row];
        end
    end

    assign x_row = x_q;

endmodule

`default_nettype wire

// ==== src/matvec_ctrl_pkg.sv ====
`default_nettype none

`include "matvec_params.svh"

package matvec_ctrl_pkg;

    typedef enum logic [1:0] {
        LOAD_MATRIX,
        LOAD_VECTOR,
        WAIT_SPACE,   // Hold until the result FIFO has drained
        COMPUTE
    } seq_state_t;

    typedef logic [$clog2(`MATVEC_N)-1:0] row_idx_t;

endpackage

`default_nettype wire

// ==== src/matvec_data_pkg.sv ====
`default_nettype none

`include "matvec_params.svh"

package matvec_data_pkg;

    typedef logic signed [`MATVEC_OPERAND_W-1:0] operand_t;

    typedef logic signed [`MATVEC_RESULT_W-1:0] product_t;  // Full width 14x14 product

    // Row sum wraps in two's complement
    typedef logic signed [`MATVEC_RESULT_W-1:0] result_t;

    // One matrix row or the whole vector
    typedef operand_t operand_row_t [`MATVEC_N];

endpackage

`default_nettype wire

// ==== src/matvec_params.svh ====
`ifndef MATVEC_PARAMS_SVH
`define MATVEC_PARAMS_SVH

// Array dimension, used for rows, columns and multiplier lanes
`define MATVEC_N 8

`define MATVEC_OPERAND_W 14
`define MATVEC_RESULT_W 28

`define MATVEC_MULT_STAGES 2  // Registers inside each lane multiplier

`define MATVEC_FIFO_DEPTH 8   // Holds exactly one full result

`endif
